// File: csu_params.svh
`ifndef CSU_PARAMS_SVH
`define CSU_PARAMS_SVH

// buffer geometry
`define CSU_DEPTH      8   // power-of-two entry count
`define CSU_TAG_BITS   3   // log2 of the depth

// datapath
`define CSU_DATA_BITS  32

// architectural registers
`define CSU_REG_COUNT  32
`define CSU_REG_BITS   5

`endif

// File: csu_pkg.sv
`default_nettype none

`include "csu_params.svh"

package csu_pkg;

    typedef logic [`CSU_TAG_BITS-1:0]  csu_tag_t;    // entry id
    typedef logic [`CSU_DATA_BITS-1:0] csu_data_t;
    typedef logic [`CSU_REG_BITS-1:0]  csu_reg_t;    // architectural register id
    typedef logic [6:0]                csu_op_t;     // opaque to the csu
    typedef logic [`CSU_TAG_BITS:0]    csu_count_t;  // holds 0 .. depth

    typedef enum logic [1:0] {
        ENTRY_EMPTY,
        ENTRY_WAITING,    // issued, operands may still be pending
        ENTRY_EXECUTING,  // handed to the execution unit
        ENTRY_DONE        // result stored, waiting for commit
    } entry_state_e;

endpackage

`default_nettype wire

// File: queue_pointers.sv
`timescale 1ns/1ns
`default_nettype none

`include "csu_params.svh"

module queue_pointers (
    input  wire logic           clk_in,
    input  wire logic           rst_in,
    input  wire logic           issue_fire,
    input  wire logic           commit_fire,
    output csu_pkg::csu_tag_t   head,
    output csu_pkg::csu_tag_t   tail,
    output logic                issue_ready
);

    csu_pkg::csu_count_t count;

    assign issue_ready = (count < csu_pkg::csu_count_t'(`CSU_DEPTH));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (issue_fire) begin
                tail <= tail + 1'b1;  // wraps since depth is a power of two
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            case ({issue_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

// File: entry_state_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "csu_params.svh"

module entry_state_table (
    input  wire logic                   clk_in,
    input  wire logic                   rst_in,
    input  wire logic                   issue_fire,
    input  wire csu_pkg::csu_tag_t      tail,
    input  wire csu_pkg::csu_tag_t      head,
    input  wire logic [`CSU_DEPTH-1:0]  operands_ready,
    input  wire logic                   exec_ready,
    input  wire logic                   result_valid,
    input  wire csu_pkg::csu_tag_t      result_tag,
    output logic                        exec_valid,
    output csu_pkg::csu_tag_t           exec_tag,
    output logic                        commit_valid,
    output csu_pkg::entry_state_e       entry_state [`CSU_DEPTH]
);

    logic [`CSU_DEPTH-1:0] can_dispatch;
    logic                  exec_fire;
    logic                  offer_held;
    csu_pkg::csu_tag_t     held_tag;

    always_comb begin
        for (int i = 0; i < `CSU_DEPTH; i++) begin
            can_dispatch[i] = (entry_state[i] == csu_pkg::ENTRY_WAITING) && operands_ready[i];
        end
    end

    // scan from the top so the lowest ready slot wins
    always_comb begin
        exec_valid = 1'b0;
        exec_tag   = '0;
        for (int i = `CSU_DEPTH - 1; i >= 0; i--) begin
            if (can_dispatch[i]) begin
                exec_valid = 1'b1;
                exec_tag   = csu_pkg::csu_tag_t'(i);
            end
        end
        if (offer_held) begin
            exec_valid = 1'b1;  // stalled offer stays until taken
            exec_tag   = held_tag;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            offer_held <= 1'b0;
            held_tag   <= '0;
        end else begin
            offer_held <= exec_valid && !exec_ready;
            held_tag   <= exec_tag;
        end
    end

    assign exec_fire    = exec_valid && exec_ready;
    assign commit_valid = (entry_state[head] == csu_pkg::ENTRY_DONE);

    // issue, dispatch, result and commit always touch different slots
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < `CSU_DEPTH; i++) begin
                entry_state[i] <= csu_pkg::ENTRY_EMPTY;
            end
        end else begin
            if (issue_fire) begin
                entry_state[tail] <= csu_pkg::ENTRY_WAITING;
            end
            if (exec_fire) begin
                entry_state[exec_tag] <= csu_pkg::ENTRY_EXECUTING;
            end
            if (result_valid) begin
                entry_state[result_tag] <= csu_pkg::ENTRY_DONE;
            end
            if (commit_valid) begin
                entry_state[head] <= csu_pkg::ENTRY_EMPTY;  // leaves only by commit
            end
        end
    end

endmodule

`default_nettype wire

// File: rename_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "csu_params.svh"

module rename_table (
    input  wire logic               clk_in,
    input  wire logic               rst_in,
    input  wire logic               issue_fire,
    input  wire csu_pkg::csu_reg_t  issue_rs1,
    input  wire csu_pkg::csu_reg_t  issue_rs2,
    input  wire csu_pkg::csu_reg_t  issue_rd,
    input  wire csu_pkg::csu_tag_t  tail,
    input  wire logic               commit_fire,
    input  wire csu_pkg::csu_reg_t  commit_rd,
    input  wire csu_pkg::csu_tag_t  head,
    output logic                    rs1_pending,
    output logic                    rs2_pending,
    output csu_pkg::csu_tag_t       rs1_tag,
    output csu_pkg::csu_tag_t       rs2_tag
);

    logic              pending [`CSU_REG_COUNT];  // slot 0 never set
    csu_pkg::csu_tag_t writer  [`CSU_REG_COUNT];
    logic              rd_renamed;
    logic              clear_on_commit;

    assign rs1_pending = (issue_rs1 != '0) && pending[issue_rs1];
    assign rs2_pending = (issue_rs2 != '0) && pending[issue_rs2];
    assign rs1_tag     = writer[issue_rs1];
    assign rs2_tag     = writer[issue_rs2];

    assign rd_renamed = issue_fire && (issue_rd != '0);

    // a younger writer, older or same-cycle, keeps the mapping alive
    assign clear_on_commit = commit_fire && pending[commit_rd]
                             && (writer[commit_rd] == head)
                             && !(issue_fire && (issue_rd == commit_rd));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int r = 0; r < `CSU_REG_COUNT; r++) begin
                pending[r] <= 1'b0;
            end
        end else begin
            if (clear_on_commit) begin
                pending[commit_rd] <= 1'b0;
            end
            if (rd_renamed) begin
                pending[issue_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_renamed) begin
            writer[issue_rd] <= tail;
        end
    end

endmodule

`default_nettype wire

// File: operand_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "csu_params.svh"

module operand_store (
    input  wire logic                   clk_in,
    input  wire logic                   rst_in,
    input  wire logic                   issue_fire,
    input  wire csu_pkg::csu_tag_t      tail,
    input  wire csu_pkg::csu_op_t       issue_op,
    input  wire csu_pkg::csu_data_t     issue_imm,
    input  wire csu_pkg::csu_reg_t      issue_rd,
    input  wire csu_pkg::csu_data_t     rf_rs1_val,
    input  wire csu_pkg::csu_data_t     rf_rs2_val,
    input  wire logic                   rs1_pending,
    input  wire logic                   rs2_pending,
    input  wire csu_pkg::csu_tag_t      rs1_tag,
    input  wire csu_pkg::csu_tag_t      rs2_tag,
    input  wire csu_pkg::entry_state_e  entry_state [`CSU_DEPTH],
    input  wire logic                   result_valid,
    input  wire csu_pkg::csu_tag_t      result_tag,
    input  wire csu_pkg::csu_data_t     result_val,
    input  wire csu_pkg::csu_tag_t      exec_tag,
    input  wire csu_pkg::csu_tag_t      head,
    output logic [`CSU_DEPTH-1:0]       operands_ready,
    output csu_pkg::csu_op_t            exec_op,
    output csu_pkg::csu_data_t          exec_imm,
    output csu_pkg::csu_data_t          exec_rs1_val,
    output csu_pkg::csu_data_t          exec_rs2_val,
    output csu_pkg::csu_reg_t           exec_rd,
    output csu_pkg::csu_reg_t           commit_rd,
    output csu_pkg::csu_data_t          commit_val
);

    csu_pkg::csu_op_t      op_q     [`CSU_DEPTH];
    csu_pkg::csu_data_t    imm_q    [`CSU_DEPTH];
    csu_pkg::csu_reg_t     rd_q     [`CSU_DEPTH];
    csu_pkg::csu_tag_t     src1_tag [`CSU_DEPTH];
    csu_pkg::csu_tag_t     src2_tag [`CSU_DEPTH];
    csu_pkg::csu_data_t    src1_val [`CSU_DEPTH];
    csu_pkg::csu_data_t    src2_val [`CSU_DEPTH];
    csu_pkg::csu_data_t    result_q [`CSU_DEPTH];  // completed results
    logic [`CSU_DEPTH-1:0] src1_rdy;
    logic [`CSU_DEPTH-1:0] src2_rdy;
    logic [`CSU_DEPTH-1:0] wake1;
    logic [`CSU_DEPTH-1:0] wake2;
    logic                  issue1_rdy;
    logic                  issue2_rdy;
    csu_pkg::csu_data_t    issue1_val;
    csu_pkg::csu_data_t    issue2_val;

    // writer already done, or finishing on this edge
    function automatic logic src_ready(input logic pending, input csu_pkg::csu_tag_t tag);
        return !pending || (entry_state[tag] == csu_pkg::ENTRY_DONE)
               || (result_valid && (result_tag == tag));
    endfunction

    function automatic csu_pkg::csu_data_t src_value(input logic pending,
                                                     input csu_pkg::csu_tag_t tag,
                                                     input csu_pkg::csu_data_t rf_val);
        if (!pending) begin
            return rf_val;
        end
        if (result_valid && (result_tag == tag)) begin
            return result_val;  // same-edge forward
        end
        return result_q[tag];  // don't care while the source waits
    endfunction

    always_comb begin
        issue1_rdy = src_ready(rs1_pending, rs1_tag);
        issue2_rdy = src_ready(rs2_pending, rs2_tag);
        issue1_val = src_value(rs1_pending, rs1_tag, rf_rs1_val);
        issue2_val = src_value(rs2_pending, rs2_tag, rf_rs2_val);
    end

    always_comb begin
        for (int i = 0; i < `CSU_DEPTH; i++) begin
            wake1[i] = result_valid && (entry_state[i] == csu_pkg::ENTRY_WAITING)
                       && !src1_rdy[i] && (src1_tag[i] == result_tag);
            wake2[i] = result_valid && (entry_state[i] == csu_pkg::ENTRY_WAITING)
                       && !src2_rdy[i] && (src2_tag[i] == result_tag);
        end
    end

    assign operands_ready = src1_rdy & src2_rdy;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            src1_rdy <= '0;
            src2_rdy <= '0;
        end else begin
            src1_rdy <= src1_rdy | wake1;
            src2_rdy <= src2_rdy | wake2;
            if (issue_fire) begin
                src1_rdy[tail] <= issue1_rdy;
                src2_rdy[tail] <= issue2_rdy;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < `CSU_DEPTH; i++) begin
            if (wake1[i]) begin
                src1_val[i] <= result_val;
            end
            if (wake2[i]) begin
                src2_val[i] <= result_val;
            end
        end
        if (result_valid) begin
            result_q[result_tag] <= result_val;
        end
        if (issue_fire) begin
            op_q[tail]     <= issue_op;
            imm_q[tail]    <= issue_imm;
            rd_q[tail]     <= issue_rd;
            src1_tag[tail] <= rs1_tag;
            src2_tag[tail] <= rs2_tag;
            src1_val[tail] <= issue1_val;
            src2_val[tail] <= issue2_val;
        end
    end

    assign exec_op      = op_q[exec_tag];
    assign exec_imm     = imm_q[exec_tag];
    assign exec_rs1_val = src1_val[exec_tag];
    assign exec_rs2_val = src2_val[exec_tag];
    assign exec_rd      = rd_q[exec_tag];

    assign commit_rd  = rd_q[head];
    assign commit_val = result_q[head];

endmodule

`default_nettype wire

// File: central_schedule_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "csu_params.svh"

module central_schedule_unit (
    input  wire logic               clk_in,
    input  wire logic               rst_in,

    input  wire logic               issue_valid,
    output wire logic               issue_ready,
    input  wire csu_pkg::csu_op_t   issue_op,
    input  wire csu_pkg::csu_data_t issue_imm,
    input  wire csu_pkg::csu_reg_t  issue_rs1,
    input  wire csu_pkg::csu_reg_t  issue_rs2,
    input  wire csu_pkg::csu_reg_t  issue_rd,

    output wire csu_pkg::csu_reg_t  rf_rs1_id,
    input  wire csu_pkg::csu_data_t rf_rs1_val,
    output wire csu_pkg::csu_reg_t  rf_rs2_id,
    input  wire csu_pkg::csu_data_t rf_rs2_val,

    output wire logic               exec_valid,
    input  wire logic               exec_ready,
    output wire csu_pkg::csu_tag_t  exec_tag,
    output wire csu_pkg::csu_op_t   exec_op,
    output wire csu_pkg::csu_data_t exec_imm,
    output wire csu_pkg::csu_data_t exec_rs1_val,
    output wire csu_pkg::csu_data_t exec_rs2_val,
    output wire csu_pkg::csu_reg_t  exec_rd,

    input  wire logic               result_valid,
    input  wire csu_pkg::csu_tag_t  result_tag,
    input  wire csu_pkg::csu_data_t result_val,

    output wire logic               commit_valid,
    output wire csu_pkg::csu_reg_t  commit_rd,
    output wire csu_pkg::csu_data_t commit_val
);

    wire logic                  issue_fire;
    wire logic                  commit_fire;
    wire csu_pkg::csu_tag_t     head;
    wire csu_pkg::csu_tag_t     tail;
    wire logic [`CSU_DEPTH-1:0] operands_ready;
    wire logic                  rs1_pending;
    wire logic                  rs2_pending;
    wire csu_pkg::csu_tag_t     rs1_tag;
    wire csu_pkg::csu_tag_t     rs2_tag;
    wire csu_pkg::csu_data_t    rs1_read;
    wire csu_pkg::csu_data_t    rs2_read;
    csu_pkg::entry_state_e      entry_state [`CSU_DEPTH];

    assign issue_fire  = issue_valid && issue_ready;
    assign commit_fire = commit_valid;  // register file never stalls

    assign rf_rs1_id = issue_rs1;
    assign rf_rs2_id = issue_rs2;
    assign rs1_read  = (issue_rs1 == '0) ? '0 : rf_rs1_val;  // x0 reads zero
    assign rs2_read  = (issue_rs2 == '0) ? '0 : rf_rs2_val;

    queue_pointers i_queue_pointers (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .issue_fire  (issue_fire),
        .commit_fire (commit_fire),
        .head        (head),
        .tail        (tail),
        .issue_ready (issue_ready)
    );

    entry_state_table i_entry_state_table (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .issue_fire     (issue_fire),
        .tail           (tail),
        .head           (head),
        .operands_ready (operands_ready),
        .exec_ready     (exec_ready),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .exec_valid     (exec_valid),
        .exec_tag       (exec_tag),
        .commit_valid   (commit_valid),
        .entry_state    (entry_state)
    );

    rename_table i_rename_table (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .issue_fire  (issue_fire),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rd    (issue_rd),
        .tail        (tail),
        .commit_fire (commit_fire),
        .commit_rd   (commit_rd),
        .head        (head),
        .rs1_pending (rs1_pending),
        .rs2_pending (rs2_pending),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag)
    );

    operand_store i_operand_store (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .issue_fire     (issue_fire),
        .tail           (tail),
        .issue_op       (issue_op),
        .issue_imm      (issue_imm),
        .issue_rd       (issue_rd),
        .rf_rs1_val     (rs1_read),
        .rf_rs2_val     (rs2_read),
        .rs1_pending    (rs1_pending),
        .rs2_pending    (rs2_pending),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .entry_state    (entry_state),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_val     (result_val),
        .exec_tag       (exec_tag),
        .head           (head),
        .operands_ready (operands_ready),
        .exec_op        (exec_op),
        .exec_imm       (exec_imm),
        .exec_rs1_val   (exec_rs1_val),
        .exec_rs2_val   (exec_rs2_val),
        .exec_rd        (exec_rd),
        .commit_rd      (commit_rd),
        .commit_val     (commit_val)
    );

endmodule

`default_nettype wire

// File: tb_central_schedule_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "csu_params.svh"

module tb_central_schedule_unit;

    localparam int NUM_INSTR  = 300;
    localparam int MAX_CYCLES = 20000;

    logic               clk_in;
    logic               rst_in;
    logic               issue_valid;
    logic               issue_ready;
    csu_pkg::csu_op_t   issue_op;
    csu_pkg::csu_data_t issue_imm;
    csu_pkg::csu_reg_t  issue_rs1;
    csu_pkg::csu_reg_t  issue_rs2;
    csu_pkg::csu_reg_t  issue_rd;
    csu_pkg::csu_reg_t  rf_rs1_id;
    csu_pkg::csu_reg_t  rf_rs2_id;
    csu_pkg::csu_data_t rf_rs1_val;
    csu_pkg::csu_data_t rf_rs2_val;
    logic               exec_valid;
    logic               exec_ready;
    csu_pkg::csu_tag_t  exec_tag;
    csu_pkg::csu_op_t   exec_op;
    csu_pkg::csu_data_t exec_imm;
    csu_pkg::csu_data_t exec_rs1_val;
    csu_pkg::csu_data_t exec_rs2_val;
    csu_pkg::csu_reg_t  exec_rd;
    logic               result_valid;
    csu_pkg::csu_tag_t  result_tag;
    csu_pkg::csu_data_t result_val;
    logic               commit_valid;
    csu_pkg::csu_reg_t  commit_rd;
    csu_pkg::csu_data_t commit_val;

    csu_pkg::csu_op_t   prog_op    [NUM_INSTR];
    csu_pkg::csu_data_t prog_imm   [NUM_INSTR];
    csu_pkg::csu_reg_t  prog_rs1   [NUM_INSTR];
    csu_pkg::csu_reg_t  prog_rs2   [NUM_INSTR];
    csu_pkg::csu_reg_t  prog_rd    [NUM_INSTR];
    csu_pkg::csu_data_t exp_src1   [NUM_INSTR];  // in-order source values
    csu_pkg::csu_data_t exp_src2   [NUM_INSTR];
    csu_pkg::csu_data_t exp_result [NUM_INSTR];

    csu_pkg::csu_data_t rf [`CSU_REG_COUNT];  // committed register file
    logic               tag_busy       [`CSU_DEPTH];
    logic               tag_dispatched [`CSU_DEPTH];
    int                 tag_owner      [`CSU_DEPTH];
    csu_pkg::csu_tag_t  fly_tag  [$];  // execution unit, items in flight
    csu_pkg::csu_data_t fly_val  [$];
    int                 fly_wait [$];

    int                 issued;
    int                 committed;
    int                 cycles;
    logic               accept_now;
    logic               dispatch_now;
    logic               commit_now;
    logic               exec_stalled;
    csu_pkg::csu_tag_t  stalled_tag;
    csu_pkg::csu_tag_t  disp_tag;
    csu_pkg::csu_data_t disp_sum;
    csu_pkg::csu_reg_t  commit_reg;
    csu_pkg::csu_data_t commit_data;

    assign rf_rs1_val = rf[rf_rs1_id];
    assign rf_rs2_val = rf[rf_rs2_id];

    central_schedule_unit i_dut (.*);

    always #20 clk_in = ~clk_in;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    // mostly low registers so dependences are frequent
    function automatic csu_pkg::csu_reg_t pick_reg();
        if (($urandom % 4) != 0) begin
            return csu_pkg::csu_reg_t'($urandom_range(7, 0));
        end
        return csu_pkg::csu_reg_t'($urandom);
    endfunction

    task automatic build_program();
        csu_pkg::csu_data_t model [`CSU_REG_COUNT];
        for (int r = 0; r < `CSU_REG_COUNT; r++) begin
            rf[r]    = $urandom;  // x0 holds junk the csu must mask
            model[r] = (r == 0) ? '0 : rf[r];
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            prog_op[i]    = csu_pkg::csu_op_t'($urandom);
            prog_imm[i]   = $urandom;
            prog_rs1[i]   = pick_reg();
            prog_rs2[i]   = pick_reg();
            prog_rd[i]    = pick_reg();
            exp_src1[i]   = model[prog_rs1[i]];
            exp_src2[i]   = model[prog_rs2[i]];
            exp_result[i] = exp_src1[i] + exp_src2[i] + prog_imm[i];
            if (prog_rd[i] != '0) begin
                model[prog_rd[i]] = exp_result[i];
            end
        end
    endtask

    // called at the falling edge, where every output is settled
    task automatic sample_cycle();
        int idx;
        accept_now   = issue_valid && issue_ready;
        dispatch_now = exec_valid && exec_ready;
        commit_now   = commit_valid;
        assert (issue_ready == ((issued - committed) < `CSU_DEPTH)) else
            mismatch("issue_ready", 32'(issue_ready), 32'((issued - committed) < `CSU_DEPTH));
        assert (rf_rs1_id == issue_rs1) else
            mismatch("rf_rs1_id", 32'(rf_rs1_id), 32'(issue_rs1));
        assert (rf_rs2_id == issue_rs2) else
            mismatch("rf_rs2_id", 32'(rf_rs2_id), 32'(issue_rs2));
        if (exec_stalled) begin
            assert (exec_valid && (exec_tag == stalled_tag)) else
                fail_now("dispatch offer changed while exec_ready was low");
        end
        if (dispatch_now) begin
            idx = tag_owner[exec_tag];
            assert (tag_busy[exec_tag] && !tag_dispatched[exec_tag]) else
                fail_now($sformatf("tag %0d dispatched while not outstanding", exec_tag));
            assert ((prog_rs1[idx] != '0 || exec_rs1_val == '0)
                    && (prog_rs2[idx] != '0 || exec_rs2_val == '0)) else
                fail_now("an x0 source was dispatched with a nonzero value");
            assert (exec_rs1_val == exp_src1[idx]) else
                mismatch("exec_rs1_val", exec_rs1_val, exp_src1[idx]);
            assert (exec_rs2_val == exp_src2[idx]) else
                mismatch("exec_rs2_val", exec_rs2_val, exp_src2[idx]);
            assert (exec_imm == prog_imm[idx]) else mismatch("exec_imm", exec_imm, prog_imm[idx]);
            assert (exec_op == prog_op[idx]) else
                mismatch("exec_op", 32'(exec_op), 32'(prog_op[idx]));
            assert (exec_rd == prog_rd[idx]) else
                mismatch("exec_rd", 32'(exec_rd), 32'(prog_rd[idx]));
            disp_tag = exec_tag;
            disp_sum = exec_rs1_val + exec_rs2_val + exec_imm;
        end
        if (commit_now) begin
            assert (committed < issued) else fail_now("commit with no instruction outstanding");
            assert (tag_dispatched[committed % `CSU_DEPTH]) else
                fail_now("an entry committed without being dispatched");
            assert (commit_rd == prog_rd[committed]) else
                mismatch("commit_rd", 32'(commit_rd), 32'(prog_rd[committed]));
            assert (commit_val == exp_result[committed]) else
                mismatch("commit_val", commit_val, exp_result[committed]);
            commit_reg  = commit_rd;
            commit_data = commit_val;
        end
        exec_stalled = exec_valid && !exec_ready;
        stalled_tag  = exec_tag;
    endtask

    task automatic apply_edge();
        if (commit_now) begin
            if (commit_reg != '0) begin
                rf[commit_reg] = commit_data;
            end
            tag_busy[committed % `CSU_DEPTH] = 1'b0;
            committed++;
        end
        if (accept_now) begin
            tag_busy[issued % `CSU_DEPTH]       = 1'b1;
            tag_dispatched[issued % `CSU_DEPTH] = 1'b0;
            tag_owner[issued % `CSU_DEPTH]      = issued;
            issued++;
        end
        foreach (fly_wait[i]) begin
            fly_wait[i]--;
        end
        if (dispatch_now) begin
            tag_dispatched[disp_tag] = 1'b1;
            fly_tag.push_back(disp_tag);
            fly_val.push_back(disp_sum);
            fly_wait.push_back($urandom_range(6, 1) - 1);  // 0 means due next edge
        end
    endtask

    // one due item per cycle, chosen at random so results return out of order
    task automatic drive_result();
        int due;
        int pick;
        int sel;
        due          = 0;
        sel          = -1;
        result_valid = 1'b0;
        foreach (fly_wait[i]) begin
            if (fly_wait[i] <= 0) begin
                due++;
            end
        end
        if (due > 0) begin
            pick = $urandom_range(due - 1, 0);
            for (int i = 0; i < fly_wait.size(); i++) begin
                if (fly_wait[i] <= 0 && sel < 0) begin
                    if (pick == 0) begin
                        sel = i;
                    end
                    pick--;
                end
            end
            result_valid = 1'b1;
            result_tag   = fly_tag[sel];
            result_val   = fly_val[sel];
            fly_tag.delete(sel);
            fly_val.delete(sel);
            fly_wait.delete(sel);
        end
    endtask

    task automatic drive_inputs();
        exec_ready = ($urandom % 3) != 0;
        if (!issue_valid || accept_now) begin  // fields held while stalled
            issue_valid = (issued < NUM_INSTR) && (($urandom % 4) != 0);
            if (issued < NUM_INSTR) begin
                issue_op  = prog_op[issued];
                issue_imm = prog_imm[issued];
                issue_rs1 = prog_rs1[issued];
                issue_rs2 = prog_rs2[issued];
                issue_rd  = prog_rd[issued];
            end
        end
    endtask

    initial begin
        void'($urandom(32'h9bbf));
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = '0;
        issue_imm    = '0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_rd     = '0;
        exec_ready   = 1'b0;
        result_valid = 1'b0;
        result_tag   = '0;
        result_val   = '0;
        issued       = 0;
        committed    = 0;
        cycles       = 0;
        exec_stalled = 1'b0;
        stalled_tag  = '0;
        for (int t = 0; t < `CSU_DEPTH; t++) begin
            tag_busy[t]       = 1'b0;
            tag_dispatched[t] = 1'b0;
            tag_owner[t]      = 0;
        end
        build_program();
        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        @(negedge clk_in);
        assert (!exec_valid && !commit_valid && issue_ready) else
            fail_now("outputs not idle after reset");
        while (committed < NUM_INSTR) begin
            if (cycles >= MAX_CYCLES) begin
                fail_now("timeout, not every instruction committed");
            end
            sample_cycle();
            @(posedge clk_in);
            #1;
            apply_edge();
            drive_result();
            drive_inputs();
            @(negedge clk_in);
            cycles++;
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: central_schedule_unit.f
+incdir+.
csu_pkg.sv
queue_pointers.sv
entry_state_table.sv
rename_table.sv
operand_store.sv
central_schedule_unit.sv
tb_central_schedule_unit.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing
TOP      ?= tb_central_schedule_unit
FILELIST ?= central_schedule_unit.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
